/* dp_cfg_pkg.sv */
`default_nettype none

package dp_cfg_pkg;

    ////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////

    // one lane of the vector word
    localparam int lane_width = 16;

    // memory word holds two lanes
    localparam int data_width = 2 * lane_width;

    // 256 words of data memory
    localparam int addr_width = 8;

    // host instruction word
    localparam int inst_width = 32;

    ////////////////////////////////////////
    // pipeline latency
    ////////////////////////////////////////

    // register stages inside the alu
    localparam int alu_stages = 2;

    // edges from instruction capture to write-back
    localparam int wb_latency = 5;

endpackage

`default_nettype wire

/* dp_isa_pkg.sv */
`default_nettype none

package dp_isa_pkg;

    ////////////////////////////////////////
    // lane-wise operations
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        op_add  = 2'd0,
        op_sub  = 2'd1,
        op_max  = 2'd2,
        op_pass = 2'd3
    } alu_op_e;

    ////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////

    // bits 28..24 and 31 are don't care
    localparam int src0_lo = 0;
    localparam int src0_hi = 7;
    localparam int src1_lo = 8;
    localparam int src1_hi = 15;
    localparam int dst_lo  = 16;
    localparam int dst_hi  = 23;
    localparam int op_lo   = 29;
    localparam int op_hi   = 30;

endpackage

`default_nettype wire

/* inst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_ctrl
    import dp_cfg_pkg::*;
    import dp_isa_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   inst_v,
    input  wire  [inst_width-1:0] inst,
    output logic                  rd_en,
    output logic [addr_width-1:0] rd_addr0,
    output logic [addr_width-1:0] rd_addr1,
    output logic                  alu_v,
    output alu_op_e               alu_op,
    output logic [addr_width-1:0] wb_addr
);

    ////////////////////////////////////////
    // delay chain storage
    ////////////////////////////////////////

    // valid and op only need to reach the alu input,
    // which sits alu_stages ahead of write-back
    logic [wb_latency-alu_stages-1:0] v_pipe;
    alu_op_e                          op_pipe [wb_latency-alu_stages];

    // destination rides all the way to write-back
    logic [addr_width-1:0] dst_pipe [wb_latency];

    // source addresses held for the memory
    logic [addr_width-1:0] src0_q;
    logic [addr_width-1:0] src1_q;

    // valid chain
    always_ff @(posedge clk) begin
        if (rst) begin
            v_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[wb_latency-alu_stages-2:0], inst_v};
        end
    end

    ////////////////////////////////////////
    // field capture and shifting
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        // stage 0 loads only on a new instruction
        if (inst_v) begin
            src0_q      <= inst[src0_hi:src0_lo];
            src1_q      <= inst[src1_hi:src1_lo];
            op_pipe[0]  <= alu_op_e'(inst[op_hi:op_lo]);
            dst_pipe[0] <= inst[dst_hi:dst_lo];
        end
        // later stages step every cycle
        for (int i = 1; i < wb_latency - alu_stages; i++) begin
            op_pipe[i] <= op_pipe[i-1];
        end
        for (int i = 1; i < wb_latency; i++) begin
            dst_pipe[i] <= dst_pipe[i-1];
        end
    end

    // read request in the cycle after capture
    assign rd_en    = v_pipe[0];
    assign rd_addr0 = src0_q;
    assign rd_addr1 = src1_q;

    // lines up with the registered read data
    assign alu_v  = v_pipe[wb_latency-alu_stages-1];
    assign alu_op = op_pipe[wb_latency-alu_stages-1];

    // lines up with out_v from the alu
    assign wb_addr = dst_pipe[wb_latency-1];

endmodule

`default_nettype wire

/* data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem
    import dp_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   load_v,
    input  wire  [data_width-1:0] load_data,
    input  wire                   rd_en,
    input  wire  [addr_width-1:0] rd_addr0,
    input  wire  [addr_width-1:0] rd_addr1,
    input  wire                   wb_en,
    input  wire  [addr_width-1:0] wb_addr,
    input  wire  [data_width-1:0] wb_data,
    output logic [data_width-1:0] rd_data0,
    output logic [data_width-1:0] rd_data1
);

    ////////////////////////////////////////
    // storage and input registers
    ////////////////////////////////////////

    (* ram_style = "block" *)
    logic [data_width-1:0] mem [2**addr_width];

    // registered load strobe and word
    logic                  load_v_q;
    logic [data_width-1:0] load_data_q;
    logic [addr_width-1:0] load_ptr;

    // registered read request
    logic                  rd_en_q;
    logic [addr_width-1:0] rd_addr0_q;
    logic [addr_width-1:0] rd_addr1_q;

    // control flops
    always_ff @(posedge clk) begin
        if (rst) begin
            load_v_q <= 1'b0;
            rd_en_q  <= 1'b0;
            load_ptr <= '0;
        end else begin
            load_v_q <= load_v;
            rd_en_q  <= rd_en;
            // wraps at the top of memory
            if (load_v_q) begin
                load_ptr <= load_ptr + 1'b1;
            end
        end
    end

    // payload flops
    always_ff @(posedge clk) begin
        load_data_q <= load_data;
        rd_addr0_q  <= rd_addr0;
        rd_addr1_q  <= rd_addr1;
    end

    ////////////////////////////////////////
    // write and read ports
    ////////////////////////////////////////

    // a pending load takes the write port
    // and a colliding write-back is lost
    always_ff @(posedge clk) begin
        if (load_v_q) begin
            mem[load_ptr] <= load_data_q;
        end else if (wb_en) begin
            mem[wb_addr] <= wb_data;
        end
    end

    // both reads see only writes from earlier edges
    always_ff @(posedge clk) begin
        if (rd_en_q) begin
            rd_data0 <= mem[rd_addr0_q];
            rd_data1 <= mem[rd_addr1_q];
        end
    end

endmodule

`default_nettype wire

/* vec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_alu
    import dp_cfg_pkg::*;
    import dp_isa_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         alu_v,
    input  wire  [$bits(alu_op_e)-1:0]  alu_op,
    input  wire  [data_width-1:0]       opa,
    input  wire  [data_width-1:0]       opb,
    output logic                        out_v,
    output logic [data_width-1:0]       out_data
);

    // stage 1 registers
    logic                  v1;
    alu_op_e               op1;
    logic [data_width-1:0] a1;
    logic [data_width-1:0] b1;

    // stage 2 input with one result per lane
    logic [data_width-1:0] lane_res;

    // one 16-bit lane where add and sub wrap
    function automatic logic [lane_width-1:0] lane_calc(
        input alu_op_e               op,
        input logic [lane_width-1:0] a,
        input logic [lane_width-1:0] b
    );
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            // unsigned compare
            op_max:  return (a > b) ? a : b;
            default: return a;
        endcase
    endfunction

    ////////////////////////////////////////
    // valid chain
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            v1    <= 1'b0;
            out_v <= 1'b0;
        end else begin
            v1    <= alu_v;
            out_v <= v1;
        end
    end

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (alu_v) begin
            a1  <= opa;
            b1  <= opb;
            op1 <= alu_op_e'(alu_op);
        end
    end

    // no carry crosses a lane boundary
    always_comb begin
        for (int l = 0; l < data_width / lane_width; l++) begin
            lane_res[l*lane_width +: lane_width] =
                lane_calc(op1, a1[l*lane_width +: lane_width], b1[l*lane_width +: lane_width]);
        end
    end

    always_ff @(posedge clk) begin
        if (v1) begin
            out_data <= lane_res;
        end
    end

endmodule

`default_nettype wire

/* vec_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_core_top
    import dp_cfg_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   load_v,
    input  wire  [data_width-1:0] load_data,
    input  wire                   inst_v,
    input  wire  [inst_width-1:0] inst,
    output logic                  res_v,
    output logic [addr_width-1:0] res_addr,
    output logic [data_width-1:0] res_data
);

    // issue side
    logic                  rd_en;
    logic [addr_width-1:0] rd_addr0;
    logic [addr_width-1:0] rd_addr1;
    logic                  alu_v;
    // two-bit opcode field
    logic [1:0]            alu_op;
    // operands and result
    logic [data_width-1:0] rd_data0;
    logic [data_width-1:0] rd_data1;
    logic                  out_v;
    logic [data_width-1:0] out_data;
    logic [addr_width-1:0] wb_addr;

    inst_ctrl u_ctrl (
        .clk, .rst, .inst_v, .inst, .rd_en, .rd_addr0, .rd_addr1, .alu_v, .alu_op, .wb_addr
    );

    data_mem u_mem (
        .clk, .rst, .load_v, .load_data, .rd_en, .rd_addr0, .rd_addr1,
        .wb_en(out_v), .wb_addr, .wb_data(out_data), .rd_data0, .rd_data1
    );

    vec_alu u_alu (
        .clk, .rst, .alu_v, .alu_op, .opa(rd_data0), .opb(rd_data1), .out_v, .out_data
    );

    // result port mirrors the write-back
    assign res_v    = out_v;
    assign res_addr = wb_addr;
    assign res_data = out_data;

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import dp_cfg_pkg::*;
    import dp_isa_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   load_v,
    input  wire  [data_width-1:0] load_data,
    input  wire                   inst_v,
    input  wire  [inst_width-1:0] inst,
    input  wire                   res_v,
    input  wire  [addr_width-1:0] res_addr,
    input  wire  [data_width-1:0] res_data,
    input  wire                   test_done,
    input  wire  [3:0]            test_num,
    input  wire  [31:0]           tb_errs,
    output int                    err_cnt,
    output int                    res_cnt
);

    // memory model and its load pointer
    logic [data_width-1:0] model [2**addr_width];
    logic [addr_width-1:0] model_ptr;
    // load word waiting for its write edge
    logic                  ld_pend;
    logic [data_width-1:0] ld_word;
    // instructions one and two edges past capture
    logic                  rd_v1;
    logic                  rd_v2;
    logic [inst_width-1:0] inst1;
    logic [inst_width-1:0] inst2;
    // expected results in issue order
    logic [addr_width-1:0] q_addr [$];
    logic [data_width-1:0] q_data [$];
    int                    q_edge [$];
    int                    edge_no;
    int                    test_base;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // two independent 16-bit lanes
    function automatic logic [data_width-1:0] alu_ref(
        input alu_op_e               op,
        input logic [data_width-1:0] a,
        input logic [data_width-1:0] b
    );
        logic [data_width-1:0] r;
        logic [lane_width-1:0] x;
        logic [lane_width-1:0] y;
        for (int l = 0; l < 2; l++) begin
            x = a[l*lane_width +: lane_width];
            y = b[l*lane_width +: lane_width];
            case (op)
                op_add:  r[l*lane_width +: lane_width] = x + y;
                op_sub:  r[l*lane_width +: lane_width] = x - y;
                op_max:  r[l*lane_width +: lane_width] = (x >= y) ? x : y;
                default: r[l*lane_width +: lane_width] = x;
            endcase
        end
        return r;
    endfunction

    function automatic string test_name(input logic [3:0] n);
        case (n)
            4'd1:    return "load and read back";
            4'd2:    return "add and subtract";
            4'd3:    return "unsigned max";
            4'd4:    return "back-to-back issue";
            4'd5:    return "dependent chain";
            4'd6:    return "reset mid-stream";
            default: return "unknown";
        endcase
    endfunction

    initial begin
        err_cnt   = 0;
        res_cnt   = 0;
        edge_no   = 0;
        test_base = 0;
        ld_pend   = 1'b0;
        rd_v1     = 1'b0;
        rd_v2     = 1'b0;
    end

    ////////////////////////////////////////
    // per-edge model and compare
    ////////////////////////////////////////

    always @(posedge clk) begin : watch
        logic [addr_width-1:0] ea;
        logic [data_width-1:0] ed;
        int                    ee;
        // operands read two edges after capture
        if (rd_v2) begin
            q_addr.push_back(inst2[dst_hi:dst_lo]);
            q_data.push_back(alu_ref(alu_op_e'(inst2[op_hi:op_lo]),
                model[inst2[src0_hi:src0_lo]], model[inst2[src1_hi:src1_lo]]));
            q_edge.push_back(edge_no + 3);
        end
        if (res_v === 1'b1) begin
            res_cnt++;
            if (q_addr.size() == 0) begin
                $display("unexpected result at %0t: res_v high with nothing in flight", $time);
                err_cnt++;
            end else begin
                ea = q_addr.pop_front();
                ed = q_data.pop_front();
                ee = q_edge.pop_front();
                if (res_addr !== ea) begin
                    $display("FAILED at %0t: res_addr expected %02h got %02h",
                        $time, ea, res_addr);
                    err_cnt++;
                end
                if (res_data !== ed) begin
                    $display("FAILED at %0t: res_data expected %08h got %08h",
                        $time, ed, res_data);
                    err_cnt++;
                end
                if (edge_no != ee) begin
                    $display("result for address %02h came %0d edges off its five-edge slot",
                        ea, edge_no - ee);
                    err_cnt++;
                end
                // a load landing on this edge wins
                if (!ld_pend) begin
                    model[ea] = ed;
                end
            end
        end
        if (ld_pend) begin
            model[model_ptr] = ld_word;
            model_ptr = model_ptr + 1'b1;
        end
        ld_pend = load_v;
        ld_word = load_data;
        rd_v2   = rd_v1;
        inst2   = inst1;
        rd_v1   = inst_v;
        inst1   = inst;
        // in-flight work is lost but memory is kept
        if (rst) begin
            q_addr.delete();
            q_data.delete();
            q_edge.delete();
            model_ptr = '0;
            ld_pend   = 1'b0;
            rd_v1     = 1'b0;
            rd_v2     = 1'b0;
        end
        if (test_done === 1'b1) begin
            $display("test %0d %s: %0d errors", test_num, test_name(test_num),
                err_cnt + tb_errs - test_base);
            test_base = err_cnt + tb_errs;
        end
        edge_no++;
    end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import dp_cfg_pkg::*;
    import dp_isa_pkg::*;
();

    logic                  clk;
    logic                  rst;
    logic                  load_v;
    logic [data_width-1:0] load_data;
    logic                  inst_v;
    logic [inst_width-1:0] inst;
    logic                  res_v;
    logic [addr_width-1:0] res_addr;
    logic [data_width-1:0] res_data;
    logic                  test_done;
    logic [3:0]            test_num;
    int                    tb_errs;
    int                    err_cnt;
    int                    res_cnt;
    // results owed by the DUT so far
    int                    issued;
    // mirror of the DUT load pointer used to pick addresses
    logic [addr_width-1:0] next_addr;

    vec_core_top uut (
        .clk, .rst, .load_v, .load_data, .inst_v, .inst, .res_v, .res_addr, .res_data
    );

    tb_checker chk (
        .clk, .rst, .load_v, .load_data, .inst_v, .inst, .res_v, .res_addr, .res_data,
        .test_done, .test_num, .tb_errs, .err_cnt, .res_cnt
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    task automatic idle_cycle();
        @(negedge clk);
        load_v = 1'b0;
        inst_v = 1'b0;
    endtask

    task automatic load_word(input logic [data_width-1:0] w);
        @(negedge clk);
        inst_v    = 1'b0;
        load_v    = 1'b1;
        load_data = w;
        next_addr = next_addr + 1'b1;
    endtask

    // junk in the ignored bits
    task automatic issue(input alu_op_e op, input int s0, input int s1, input int d);
        @(negedge clk);
        load_v = 1'b0;
        inst_v = 1'b1;
        inst   = $urandom;
        inst[op_hi:op_lo]     = op;
        inst[src0_hi:src0_lo] = s0[addr_width-1:0];
        inst[src1_hi:src1_lo] = s1[addr_width-1:0];
        inst[dst_hi:dst_lo]   = d[addr_width-1:0];
        issued++;
    endtask

    task automatic wait_results(input string what);
        int t;
        t = 0;
        while (res_cnt < issued && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (res_cnt < issued) begin
            $display("timeout in %s: %0d results seen, %0d issued", what, res_cnt, issued);
            tb_errs++;
        end
    endtask

    // idle gap lets strays show up before the report
    task automatic finish_test(input logic [3:0] n);
        repeat (6) idle_cycle();
        test_num  = n;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int base;
        void'($urandom(32'hb536));
        rst       = 1'b1;
        load_v    = 1'b0;
        load_data = '0;
        inst_v    = 1'b0;
        inst      = '0;
        test_done = 1'b0;
        test_num  = '0;
        tb_errs   = 0;
        issued    = 0;
        next_addr = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // fill the whole memory then copy the low half up
        for (int i = 0; i < 256; i++) load_word($urandom);
        idle_cycle();
        for (int s = 0; s < 128; s++) issue(op_pass, s, $urandom % 256, 255 - s);
        idle_cycle();
        wait_results("load and read back");
        finish_test(4'd1);

        // lane overflow and underflow
        base = next_addr;
        load_word(32'hffff_8000);
        load_word(32'h0001_8000);
        load_word(32'h0000_0001);
        load_word(32'h0001_0002);
        load_word($urandom);
        load_word($urandom);
        idle_cycle();
        issue(op_add, base, base + 1, 200);
        issue(op_sub, base + 2, base + 3, 201);
        issue(op_sub, base + 3, base + 2, 202);
        issue(op_add, base + 4, base + 5, 203);
        issue(op_sub, base + 5, base + 4, 204);
        issue(op_add, base, base, 205);
        idle_cycle();
        wait_results("add and subtract");
        finish_test(4'd2);

        // top bits set so a signed compare would flip these
        base = next_addr;
        load_word(32'h8000_7fff);
        load_word(32'h7fff_8000);
        load_word(32'hffff_0001);
        load_word(32'h0001_ffff);
        idle_cycle();
        issue(op_max, base, base + 1, 206);
        issue(op_max, base + 1, base, 207);
        issue(op_max, base + 2, base + 3, 208);
        issue(op_max, base + 3, base + 2, 209);
        issue(op_max, base, base + 2, 210);
        idle_cycle();
        wait_results("unsigned max");
        finish_test(4'd3);

        // sources in the low half and destinations in the high half
        for (int i = 0; i < 40; i++) begin
            issue(alu_op_e'(2'($urandom)), $urandom % 128, $urandom % 128,
                128 + $urandom % 128);
        end
        idle_cycle();
        wait_results("back-to-back issue");
        finish_test(4'd4);

        // four-cycle spacing where each reads the last result
        issue(alu_op_e'(2'($urandom)), $urandom % 128, $urandom % 128, 211);
        for (int i = 1; i < 10; i++) begin
            repeat (3) idle_cycle();
            issue(alu_op_e'(2'($urandom)), 210 + i, $urandom % 128, 211 + i);
        end
        idle_cycle();
        wait_results("dependent chain");
        finish_test(4'd5);

        // three in flight when reset hits
        for (int i = 0; i < 3; i++) issue(op_add, i, i + 1, 130 + i);
        @(negedge clk);
        inst_v = 1'b0;
        rst    = 1'b1;
        for (int i = 0; i < 16; i++) begin
            if (i == 4) begin
                rst = 1'b0;
            end
            @(negedge clk);
            if (res_v !== 1'b0) begin
                $display("res_v went high at %0t after reset dropped the pipe", $time);
                tb_errs++;
            end
        end
        issued    = res_cnt;
        next_addr = '0;
        for (int i = 0; i < 3; i++) load_word($urandom);
        idle_cycle();
        for (int i = 0; i < 3; i++) issue(op_pass, i, 0, 240 + i);
        idle_cycle();
        wait_results("reset mid-stream");
        finish_test(4'd6);

        $display("summary: %0d results, %0d checker errors, %0d testbench errors",
            res_cnt, err_cnt, tb_errs);
        if (err_cnt == 0 && tb_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
dp_cfg_pkg.sv
dp_isa_pkg.sv
inst_ctrl.sv
data_mem.sv
vec_alu.sv
vec_core_top.sv
tb_checker.sv
tb_top.sv
